// ==== hw/device_info_pkg.sv ====
package device_info_pkg;

	//////////////////////////////////////////////////
	// widths

	localparam int dna_bits_c   = 57;	// die serial length
	localparam int serial_w_c   = 64;	// padded serial register
	localparam int cfg_w_c      = 32;	// config port word
	localparam int script_len_c = 8;	// words in the command script

	//////////////////////////////////////////////////
	// config packets

	// type-1 header opcode
	typedef enum logic [1:0] {
		op_nop   = 2'b00,
		op_read  = 2'b01,
		op_write = 2'b10
	} cfg_op_e;

	localparam logic [2:0]  hdr_type1_c  = 3'b001;
	localparam logic [13:0] reg_idcode_c = 14'h000c;	// IDCODE register address

	// one config word, either plain data or a type-1 header
	typedef union packed {
		logic [cfg_w_c-1:0] raw;
		struct packed {
			logic [2:0]  hdr_type;
			cfg_op_e     op;
			logic [13:0] reg_addr;
			logic [1:0]  rsvd;
			logic [10:0] word_cnt;
		} hdr;
	} cfg_word_t;

	localparam logic [cfg_w_c-1:0] dummy_word_c      = 32'hffff_ffff;
	localparam logic [cfg_w_c-1:0] bus_width1_c      = 32'h0000_00bb;	// bus width detect
	localparam logic [cfg_w_c-1:0] bus_width2_c      = 32'h1122_0044;
	localparam logic [cfg_w_c-1:0] sync_word_c       = 32'haa99_5566;
	localparam logic [cfg_w_c-1:0] nop_word_c        = 32'h2000_0000;	// type 1, op nop
	localparam logic [cfg_w_c-1:0] idcode_read_hdr_c = 32'h2801_8001;	// read 1 word of IDCODE

	// command script, index 0 goes out first
	localparam logic [cfg_w_c-1:0] script_c [script_len_c] = '{
		dummy_word_c,
		bus_width1_c,
		bus_width2_c,
		dummy_word_c,
		dummy_word_c,
		sync_word_c,
		nop_word_c,	// one nop needed after sync
		idcode_read_hdr_c
	};

	//////////////////////////////////////////////////
	// state encodings

	typedef enum logic [1:0] {
		dna_st_boot  = 2'd0,
		dna_st_load  = 2'd1,
		dna_st_shift = 2'd2,
		dna_st_done  = 2'd3
	} dna_state_e;

	typedef enum logic [2:0] {
		cfg_st_idle      = 3'd0,
		cfg_st_write     = 3'd1,
		cfg_st_flush     = 3'd2,
		cfg_st_turn      = 3'd3,
		cfg_st_read_wait = 3'd4,
		cfg_st_done      = 3'd5
	} cfg_state_e;

endpackage

// ==== hw/dna_reader.sv ====
module dna_reader #(
	parameter int boot_wait = 128
) (
	input  logic clk,
	input  logic rst_n,
	input  logic dna_dout,	// serial port MSB
	output logic dna_read,
	output logic dna_shift,
	output logic serial_bit,
	output logic serial_shift_en,
	output logic serial_done
);

	// one counter covers both the boot wait and the bit count
	localparam int cnt_max = (boot_wait > device_info_pkg::dna_bits_c) ?
		boot_wait : device_info_pkg::dna_bits_c;
	localparam int cnt_w = $clog2(cnt_max + 1);

	device_info_pkg::dna_state_e state;
	logic [cnt_w-1:0]            cnt;

	//////////////////////////////////////////////////
	// boot wait, load strobe, shift

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state       <= device_info_pkg::dna_st_boot;
			cnt         <= '0;
			dna_read    <= 1'b0;
			dna_shift   <= 1'b0;
			serial_done <= 1'b0;
		end else begin
			dna_read    <= 1'b0;	// strobes default low
			serial_done <= 1'b0;
			case (state)
				device_info_pkg::dna_st_boot: begin
					// let everything settle after reset
					cnt <= cnt + 1'b1;
					if (cnt == cnt_w'(boot_wait - 1)) begin
						dna_read <= 1'b1;
						cnt      <= '0;
						state    <= device_info_pkg::dna_st_load;
					end
				end
				device_info_pkg::dna_st_load: begin
					dna_shift <= 1'b1;	// port loaded, start shifting
					state     <= device_info_pkg::dna_st_shift;
				end
				device_info_pkg::dna_st_shift: begin
					cnt <= cnt + 1'b1;	// one bit per clock
					if (cnt == cnt_w'(device_info_pkg::dna_bits_c - 1)) begin
						dna_shift   <= 1'b0;
						serial_done <= 1'b1;	// last bit taken this edge
						state       <= device_info_pkg::dna_st_done;
					end
				end
				default: begin
					// hold here until the next reset
				end
			endcase
		end
	end

	// every clock with shift high carries one valid bit
	assign serial_bit      = dna_dout;
	assign serial_shift_en = dna_shift;

endmodule

// ==== hw/cfg_script_decode.sv ====
module cfg_script_decode (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       start,	// serial read finished
	input  logic                       word_taken,
	output device_info_pkg::cfg_word_t word,
	output logic                       word_valid,
	output logic                       word_is_read_hdr,
	output logic                       script_end
);

	localparam int idx_w = $clog2(device_info_pkg::script_len_c);

	logic [idx_w-1:0] idx;
	logic             active;
	logic             last_word;

	//////////////////////////////////////////////////
	// script index

	assign last_word = (idx == idx_w'(device_info_pkg::script_len_c - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			idx    <= '0;
			active <= 1'b0;
		end else if (start) begin
			idx    <= '0;	// restart from the first word
			active <= 1'b1;
		end else if (active && word_taken) begin
			if (last_word) begin
				active <= 1'b0;	// script fully handed over
			end else begin
				idx <= idx + 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////
	// decode current word

	always_comb begin
		word.raw = device_info_pkg::script_c[idx];
	end

	assign word_valid = active;
	assign script_end = active && last_word;

	// type-1 read aimed at IDCODE arms the readback
	always_comb begin
		word_is_read_hdr = 1'b0;
		if (active &&
			word.hdr.hdr_type == device_info_pkg::hdr_type1_c &&
			word.hdr.op == device_info_pkg::op_read &&
			word.hdr.reg_addr == device_info_pkg::reg_idcode_c) begin
			word_is_read_hdr = 1'b1;
		end
	end

endmodule

// ==== hw/cfg_port_exec.sv ====
module cfg_port_exec #(
	parameter int read_latency = 3,
	parameter int flush_nops   = 3
) (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  device_info_pkg::cfg_word_t           word,
	input  logic                                 word_valid,
	input  logic                                 word_is_read_hdr,
	input  logic                                 script_end,
	input  logic [device_info_pkg::cfg_w_c-1:0]  cfg_dout,	// byte-reversed from port
	output logic                                 cfg_cs_n,
	output logic                                 cfg_wr_n,
	output logic [device_info_pkg::cfg_w_c-1:0]  cfg_din,	// byte-reversed to port
	output logic                                 word_taken,
	output logic [device_info_pkg::cfg_w_c-1:0]  id_data,
	output logic                                 id_capture
);

	// counter shared by flush, turnaround and read wait
	localparam int cnt_max = (flush_nops > read_latency) ? flush_nops : read_latency;
	localparam int cnt_w   = $clog2(cnt_max + 3);

	device_info_pkg::cfg_state_e         state;
	logic [cnt_w-1:0]                    cnt;
	logic [device_info_pkg::cfg_w_c-1:0] out_word;	// word in normal bit order
	logic                                read_armed;	// read header went out

	//////////////////////////////////////////////////
	// per-byte bit reversal in both directions

	for (genvar b = 0; b < device_info_pkg::cfg_w_c / 8; b++) begin : g_byte
		for (genvar g = 0; g < 8; g++) begin : g_bit
			assign cfg_din[b*8 + g] = out_word[b*8 + 7 - g];
			assign id_data[b*8 + g] = cfg_dout[b*8 + 7 - g];
		end
	end

	// one script word consumed per write cycle
	assign word_taken = (state == device_info_pkg::cfg_st_write) && word_valid;

	//////////////////////////////////////////////////
	// port sequencing

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= device_info_pkg::cfg_st_idle;
			cnt        <= '0;
			cfg_cs_n   <= 1'b1;
			cfg_wr_n   <= 1'b1;
			id_capture <= 1'b0;
			read_armed <= 1'b0;
		end else begin
			id_capture <= 1'b0;
			case (state)
				device_info_pkg::cfg_st_idle: begin
					if (word_valid) begin
						cfg_wr_n <= 1'b0;	// write mode while still deselected
						state    <= device_info_pkg::cfg_st_write;
					end
				end
				device_info_pkg::cfg_st_write: begin
					cfg_cs_n <= 1'b0;
					if (word_is_read_hdr)
						read_armed <= 1'b1;
					if (script_end) begin
						cnt   <= '0;
						state <= (flush_nops == 0) ? device_info_pkg::cfg_st_turn :
							device_info_pkg::cfg_st_flush;
					end
				end
				device_info_pkg::cfg_st_flush: begin
					// nops push the read through the pipeline
					cnt <= cnt + 1'b1;
					if (cnt == cnt_w'(flush_nops - 1)) begin
						cnt   <= '0;
						state <= device_info_pkg::cfg_st_turn;
					end
				end
				device_info_pkg::cfg_st_turn: begin
					cnt <= cnt + 1'b1;
					case (cnt)
						cnt_w'(0): cfg_cs_n <= 1'b1;	// deselect
						cnt_w'(1): cfg_wr_n <= 1'b1;	// read mode while idle
						default: begin
							cfg_cs_n <= 1'b0;	// reselect for readback
							cnt      <= '0;
							state    <= device_info_pkg::cfg_st_read_wait;
						end
					endcase
				end
				device_info_pkg::cfg_st_read_wait: begin
					cnt <= cnt + 1'b1;
					if (cnt == cnt_w'(read_latency - 1)) begin
						id_capture <= read_armed;	// data valid on the port now
						state      <= device_info_pkg::cfg_st_done;
					end
				end
				default: begin
					cfg_cs_n <= 1'b1;	// park deselected
				end
			endcase
		end
	end

	// next word for the port
	always_ff @(posedge clk) begin
		if (word_taken) begin
			out_word <= word.raw;
		end else if (state == device_info_pkg::cfg_st_flush) begin
			out_word <= device_info_pkg::nop_word_c;
		end
	end

endmodule

// ==== hw/info_result.sv ====
module info_result (
	input  logic                                   clk,
	input  logic                                   rst_n,
	input  logic                                   serial_bit,
	input  logic                                   serial_shift_en,
	input  logic                                   serial_done,
	input  logic [device_info_pkg::cfg_w_c-1:0]    id_data,
	input  logic                                   id_capture,
	output logic [device_info_pkg::serial_w_c-1:0] die_serial,
	output logic                                   serial_valid,
	output logic [device_info_pkg::cfg_w_c-1:0]    idcode,
	output logic                                   idcode_valid
);

	localparam int pad_w = device_info_pkg::serial_w_c - device_info_pkg::dna_bits_c;

	logic [device_info_pkg::dna_bits_c-1:0] dna_sr;

	//////////////////////////////////////////////////
	// payload registers

	always_ff @(posedge clk) begin
		if (serial_shift_en)
			dna_sr <= {dna_sr[device_info_pkg::dna_bits_c-2:0], serial_bit};	// msb first
		if (id_capture)
			idcode <= id_data;
	end

	assign die_serial = {{pad_w{1'b0}}, dna_sr};	// zero pad above the serial

	//////////////////////////////////////////////////
	// valid levels

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			serial_valid <= 1'b0;
			idcode_valid <= 1'b0;
		end else begin
			if (serial_done)
				serial_valid <= 1'b1;	// one cycle after last shift
			if (id_capture)
				idcode_valid <= 1'b1;	// same edge as idcode load
		end
	end

endmodule

// ==== hw/device_info.sv ====
module device_info #(
	parameter int boot_wait    = 128,
	parameter int read_latency = 3,
	parameter int flush_nops   = 3
) (
	input  logic                                   clk,
	input  logic                                   rst_n,
	input  logic                                   dna_dout,
	input  logic [device_info_pkg::cfg_w_c-1:0]    cfg_dout,
	output logic                                   dna_read,
	output logic                                   dna_shift,
	output logic                                   cfg_cs_n,
	output logic                                   cfg_wr_n,
	output logic [device_info_pkg::cfg_w_c-1:0]    cfg_din,
	output logic [device_info_pkg::serial_w_c-1:0] die_serial,
	output logic                                   serial_valid,
	output logic [device_info_pkg::cfg_w_c-1:0]    idcode,
	output logic                                   idcode_valid
);

	logic                                serial_bit;
	logic                                serial_shift_en;
	logic                                serial_done;	// also kicks off the script
	device_info_pkg::cfg_word_t          word;
	logic                                word_valid;
	logic                                word_is_read_hdr;
	logic                                script_end;
	logic                                word_taken;
	logic [device_info_pkg::cfg_w_c-1:0] id_data;
	logic                                id_capture;

	//////////////////////////////////////////////////
	// die serial

	dna_reader #(
		.boot_wait(boot_wait)
	) u_dna_reader (
		.clk            (clk),
		.rst_n          (rst_n),
		.dna_dout       (dna_dout),
		.dna_read       (dna_read),
		.dna_shift      (dna_shift),
		.serial_bit     (serial_bit),
		.serial_shift_en(serial_shift_en),
		.serial_done    (serial_done)
	);

	//////////////////////////////////////////////////
	// IDCODE over the config port

	cfg_script_decode u_decode (
		.clk             (clk),
		.rst_n           (rst_n),
		.start           (serial_done),
		.word_taken      (word_taken),
		.word            (word),
		.word_valid      (word_valid),
		.word_is_read_hdr(word_is_read_hdr),
		.script_end      (script_end)
	);

	cfg_port_exec #(
		.read_latency(read_latency),
		.flush_nops  (flush_nops)
	) u_exec (
		.clk             (clk),
		.rst_n           (rst_n),
		.word            (word),
		.word_valid      (word_valid),
		.word_is_read_hdr(word_is_read_hdr),
		.script_end      (script_end),
		.cfg_dout        (cfg_dout),
		.cfg_cs_n        (cfg_cs_n),
		.cfg_wr_n        (cfg_wr_n),
		.cfg_din         (cfg_din),
		.word_taken      (word_taken),
		.id_data         (id_data),
		.id_capture      (id_capture)
	);

	//////////////////////////////////////////////////
	// results

	info_result u_result (
		.clk            (clk),
		.rst_n          (rst_n),
		.serial_bit     (serial_bit),
		.serial_shift_en(serial_shift_en),
		.serial_done    (serial_done),
		.id_data        (id_data),
		.id_capture     (id_capture),
		.die_serial     (die_serial),
		.serial_valid   (serial_valid),
		.idcode         (idcode),
		.idcode_valid   (idcode_valid)
	);

endmodule

// ==== verif/device_info_checker.sv ====
module device_info_checker #(
	parameter int flush_nops = 3
) (
	input  logic                                   clk,
	input  logic                                   rst_n,
	input  logic                                   dna_read,
	input  logic                                   dna_shift,
	input  logic                                   cfg_cs_n,
	input  logic                                   cfg_wr_n,
	input  logic [device_info_pkg::cfg_w_c-1:0]    cfg_din,	// byte-reversed on the wire
	input  logic [device_info_pkg::serial_w_c-1:0] die_serial,
	input  logic                                   serial_valid,
	input  logic [device_info_pkg::cfg_w_c-1:0]    idcode,
	input  logic                                   idcode_valid,
	input  logic [device_info_pkg::dna_bits_c-1:0] exp_serial,
	input  logic [device_info_pkg::cfg_w_c-1:0]    exp_idcode,
	input  int                                     case_idx,
	input  logic                                   case_end,	// pulse at the end of a case
	output int                                     pass_cnt,
	output int                                     fail_cnt
);

	localparam int          n_writes = 8 + flush_nops;	// script plus flush
	localparam logic [31:0] nop_c    = 32'h2000_0000;
	localparam int          pad_w    = device_info_pkg::serial_w_c - device_info_pkg::dna_bits_c;

	logic started      = 1'b0;	// first reset seen
	logic rst_q        = 1'b0;
	logic sv_q         = 1'b0;
	logic iv_q         = 1'b0;
	logic serial_seen  = 1'b0;
	logic wr_high_seen = 1'b0;	// wr_n back high after writes
	int   wr_idx       = 0;
	int   case_errs    = 0;
	int   n_pass       = 0;
	int   n_fail       = 0;

	assign pass_cnt = n_pass;
	assign fail_cnt = n_fail;

	// undo the port's per-byte bit order
	function automatic logic [31:0] reverse_byte_bits(input logic [31:0] w);
		logic [31:0] r;
		for (int b = 0; b < 4; b++)
			for (int k = 0; k < 8; k++)
				r[b*8 + k] = w[b*8 + 7 - k];
		return r;
	endfunction

	// command stream in write order
	function automatic logic [31:0] expected_write(input int idx);
		case (idx)
			0, 3, 4: return 32'hffff_ffff;	// dummy words
			1:       return 32'h0000_00bb;	// bus width detect
			2:       return 32'h1122_0044;
			5:       return 32'haa99_5566;	// sync
			7:       return 32'h2801_8001;	// type 1 read, IDCODE, one word
			default: return nop_c;	// nop after sync, then flush
		endcase
	endfunction

	task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			$display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
			case_errs++;
		end
	endtask

	task automatic report_problem(input string msg);
		$display("at %0t, case %0d: %s", $time, case_idx, msg);
		case_errs++;
	endtask

	//////////////////////////////////////////////////
	// port monitor

	always @(posedge clk) begin
		if (!rst_n || (started && !rst_q)) begin
			// in reset and the first edge after it
			started = 1'b1;
			check_value("serial_valid", serial_valid, 1'b0);
			check_value("idcode_valid", idcode_valid, 1'b0);
			check_value("cfg_cs_n", cfg_cs_n, 1'b1);
			check_value("cfg_wr_n", cfg_wr_n, 1'b1);
			check_value("dna_read", dna_read, 1'b0);
			check_value("dna_shift", dna_shift, 1'b0);
			wr_idx       = 0;	// run starts over
			serial_seen  = 1'b0;
			wr_high_seen = 1'b0;
		end else if (started) begin
			if (serial_valid && !sv_q) begin
				check_value("die_serial", die_serial, {{pad_w{1'b0}}, exp_serial});
				serial_seen = 1'b1;
			end
			if (!cfg_cs_n && !cfg_wr_n) begin
				if (wr_idx == 0 && !serial_valid)
					report_problem("config write started before serial_valid");
				if (wr_idx < n_writes)
					check_value($sformatf("cfg_din word %0d", wr_idx),
						reverse_byte_bits(cfg_din), expected_write(wr_idx));
				else
					report_problem("config write after the last flush nop");
				wr_idx++;
			end else if (wr_idx > 0 && cfg_wr_n) begin
				wr_high_seen = 1'b1;
			end
			if (idcode_valid && !iv_q) begin
				check_value("idcode", idcode, exp_idcode);
				if (!wr_high_seen)
					report_problem("idcode_valid rose before wr_n went back high");
				if (wr_idx != n_writes)
					report_problem($sformatf("only %0d of %0d words written before readback",
						wr_idx, n_writes));
			end
		end
		if (case_end) begin
			if (!serial_seen)
				report_problem("serial_valid never rose");
			if (case_errs == 0) begin
				$display("case %0d: ok, serial %h idcode %h", case_idx, exp_serial, exp_idcode);
				n_pass++;
			end else begin
				$display("case %0d: %0d mismatches", case_idx, case_errs);
				n_fail++;
			end
			case_errs = 0;
		end
		rst_q = rst_n;	// edge history
		sv_q  = serial_valid;
		iv_q  = idcode_valid;
	end

endmodule

// ==== verif/device_info_tb.sv ====
module device_info_tb;

	localparam int boot_wait_c    = 16;	// short boot delay
	localparam int read_latency_c = 3;
	localparam int flush_nops_c   = 3;
	localparam int max_cases      = 64;
	localparam int dna_w          = device_info_pkg::dna_bits_c;
	localparam int rand_span      = boot_wait_c + dna_w + 40;	// reaches into the script
	localparam int case_cycles    = boot_wait_c + dna_w + device_info_pkg::script_len_c +
		flush_nops_c + read_latency_c + 40;
	localparam logic [31:0] read_hdr_c = 32'h2801_8001;	// type 1 read of IDCODE
	localparam logic [63:0] no_case    = '1;	// past the end of the table
	localparam logic [63:0] rand_abort = 64'hffff;

	logic              clk;
	logic              rst_n      = 1'b1;
	logic              dna_dout;
	logic              dna_read;
	logic              dna_shift;
	logic              cfg_cs_n;
	logic              cfg_wr_n;
	logic [31:0]       cfg_din;
	logic [31:0]       cfg_dout   = '0;
	logic [63:0]       die_serial;
	logic              serial_valid;
	logic [31:0]       idcode;
	logic              idcode_valid;
	logic [dna_w-1:0]  cur_serial = '0;
	logic [31:0]       cur_idcode = '0;
	logic [dna_w-1:0]  dna_sr     = '0;	// serial port shift register
	logic              rd_armed   = 1'b0;
	int                rd_cnt     = 0;
	int                case_idx   = 0;
	logic              case_end   = 1'b0;
	logic [63:0]       case_mem [3*max_cases];	// serial, idcode, abort per case
	int                abort_cyc [max_cases];
	int                n_cases     = 0;
	int                cycle_limit = 0;
	int                cycle_cnt   = 0;
	int                pass_cnt;
	int                fail_cnt;

	device_info #(
		.boot_wait   (boot_wait_c),
		.read_latency(read_latency_c),
		.flush_nops  (flush_nops_c)
	) i_dut (
		.clk         (clk),
		.rst_n       (rst_n),
		.dna_dout    (dna_dout),
		.cfg_dout    (cfg_dout),
		.dna_read    (dna_read),
		.dna_shift   (dna_shift),
		.cfg_cs_n    (cfg_cs_n),
		.cfg_wr_n    (cfg_wr_n),
		.cfg_din     (cfg_din),
		.die_serial  (die_serial),
		.serial_valid(serial_valid),
		.idcode      (idcode),
		.idcode_valid(idcode_valid)
	);

	device_info_checker #(
		.flush_nops(flush_nops_c)
	) i_chk (
		.clk(clk), .rst_n(rst_n), .dna_read(dna_read), .dna_shift(dna_shift),
		.cfg_cs_n(cfg_cs_n), .cfg_wr_n(cfg_wr_n), .cfg_din(cfg_din),
		.die_serial(die_serial), .serial_valid(serial_valid),
		.idcode(idcode), .idcode_valid(idcode_valid),
		.exp_serial(cur_serial), .exp_idcode(cur_idcode),
		.case_idx(case_idx), .case_end(case_end),
		.pass_cnt(pass_cnt), .fail_cnt(fail_cnt)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] reverse_byte_bits(input logic [31:0] w);
		logic [31:0] r;
		for (int b = 0; b < 4; b++)
			for (int k = 0; k < 8; k++)
				r[b*8 + k] = w[b*8 + 7 - k];
		return r;
	endfunction

	task automatic pulse_reset();
		rst_n <= 1'b0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
	endtask

	//////////////////////////////////////////////////
	// port models

	assign dna_dout = dna_sr[dna_w-1];	// msb out first

	always @(posedge clk) begin
		if (dna_read)
			dna_sr <= cur_serial;
		else if (dna_shift)
			dna_sr <= {dna_sr[dna_w-2:0], 1'b0};
	end

	always @(posedge clk) begin
		if (!rst_n) begin
			rd_armed <= 1'b0;
			rd_cnt   <= 0;
			cfg_dout <= '0;
		end else if (!cfg_cs_n && !cfg_wr_n) begin
			rd_cnt <= 0;	// write cycle
			if (reverse_byte_bits(cfg_din) == read_hdr_c)
				rd_armed <= 1'b1;
		end else if (!cfg_cs_n && cfg_wr_n && rd_armed) begin
			rd_cnt <= rd_cnt + 1;	// selected in read mode
			if (rd_cnt == read_latency_c - 1)
				cfg_dout <= reverse_byte_bits(cur_idcode);	// held from here on
		end
	end

	//////////////////////////////////////////////////
	// cases and run control

	initial begin
		int unsigned seed_val;
		logic [63:0] abort_field;
		int          i;
		seed_val = $urandom(75069);	// seeds the run
		for (i = 0; i < 3*max_cases; i++)
			case_mem[i] = no_case;
		$readmemh("verif/device_info_cases.txt", case_mem);
		while (n_cases < max_cases && case_mem[3*n_cases] != no_case) begin
			abort_field = case_mem[3*n_cases + 2];
			if (abort_field == rand_abort)
				abort_cyc[n_cases] = 1 + int'($urandom % rand_span);
			else
				abort_cyc[n_cases] = int'(abort_field);
			cycle_limit += case_cycles + abort_cyc[n_cases];
			n_cases++;
		end
		for (i = 0; i < n_cases; i++) begin
			@(posedge clk);
			cur_serial <= case_mem[3*i][dna_w-1:0];
			cur_idcode <= case_mem[3*i + 1][31:0];
			case_idx   <= i;
			pulse_reset();
			if (abort_cyc[i] != 0) begin
				repeat (abort_cyc[i]) @(posedge clk);
				pulse_reset();	// mid-run abort
			end
			@(posedge clk);
			while (!idcode_valid)
				@(posedge clk);
			@(posedge clk);
			case_end <= 1'b1;
			@(posedge clk);
			case_end <= 1'b0;
		end
		@(posedge clk);
		$display("%0d cases: %0d passed, %0d failed", n_cases, pass_cnt, fail_cnt);
		if (n_cases > 0 && fail_cnt == 0 && pass_cnt == n_cases) begin
			$display("TB PASSED");
		end else begin
			if (n_cases == 0)
				$display("no cases found in verif/device_info_cases.txt");
			$display("TB FAILED");
		end
		$finish;
	end

	// whole-run cycle budget
	initial begin
		wait (cycle_limit != 0);
		while (cycle_cnt < cycle_limit) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("timeout: case %0d still running after %0d cycles", case_idx, cycle_limit);
		$display("TB FAILED");
		$finish;
	end

endmodule

// ==== verif/device_info_cases.txt ====
// die serial (57 bits), IDCODE, reset-abort cycle after reset release, all hex
// abort 0 runs straight through, abort ffff picks a random cycle
0123456789abcde 0362d093 0
1ffffffffffffff 13631093 0
000000000000001 0372c093 0
155555555555555 04a62093 14
0aaaaaaaaaaaaaa 03651093 30
1f0e1d2c3b4a596 1234abcd 0
000000000000000 0364c093 48
0fedcba98765432 0ba00477 ffff
13579bdf0246800 4ba00477 ffff
1800000000000ff 80000001 5
0c3c3c3c3c3c3c3 13722093 53

// ==== device_info.f ====
hw/device_info_pkg.sv
hw/dna_reader.sv
hw/cfg_script_decode.sv
hw/cfg_port_exec.sv
hw/info_result.sv
hw/device_info.sv
verif/device_info_checker.sv
verif/device_info_tb.sv

// ==== Bender.yml ====
package:
  name: device_info

sources:
  - hw/device_info_pkg.sv
  - hw/dna_reader.sv
  - hw/cfg_script_decode.sv
  - hw/cfg_port_exec.sv
  - hw/info_result.sv
  - hw/device_info.sv
  - target: test
    files:
      - verif/device_info_checker.sv
      - verif/device_info_tb.sv
